//--- hdl/core_cfg_pkg.sv
package core_cfg_pkg;

	// rename group width
	localparam int N_LANES = 4;

	// architectural register index
	localparam int WIDTH_ARCH = 5;
	localparam int N_ARCH = 2 ** WIDTH_ARCH;

	// physical tag, 128 registers in all
	localparam int WIDTH_PRD = 7;
	localparam int N_PRD = 2 ** WIDTH_PRD;

	// bank select sits in the top bits of a tag
	localparam int WIDTH_BANK = 2;

	// slots per free list bank
	localparam int BANK_DEPTH = 32;
	localparam int WIDTH_SLOT = $clog2(BANK_DEPTH);
	// one extra bit so a full bank can be told from an empty one
	localparam int WIDTH_CNT = WIDTH_SLOT + 1;

	// three execute pipes write back
	localparam int N_WB = 3;

	// commit width
	localparam int N_COM = 4;

endpackage

//--- hdl/rename_enc_pkg.sv
package rename_enc_pkg;

	// tag 0 is the hardwired zero register
	// never allocated, never busy, the reset mapping of every arch reg
	localparam logic [core_cfg_pkg::WIDTH_PRD-1:0] PRD_ZERO = '0;

	// rd of 0 means no destination
	localparam logic [core_cfg_pkg::WIDTH_ARCH-1:0] ARCH_ZERO = '0;

	// bank 0 skips tag 0 and holds 31 tags
	localparam int BANK0_FIRST = 1;

	// bank b covers b*32 up to b*32+31
	localparam int BANK_STRIDE = core_cfg_pkg::BANK_DEPTH;

endpackage

//--- hdl/busy_if.sv
`timescale 1ns/1ps

interface busy_if;

	// set on rename
	logic [core_cfg_pkg::N_LANES-1:0]                           set_mask;
	logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] set_prd;

	// source lookups
	logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] look_rs1;
	logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] look_rs2;
	logic [core_cfg_pkg::N_LANES-1:0]                           busy1;
	logic [core_cfg_pkg::N_LANES-1:0]                           busy2;

	modport map_side (output set_mask, set_prd, look_rs1, look_rs2,
	                  input  busy1, busy2);

	modport table_side (input  set_mask, set_prd, look_rs1, look_rs2,
	                    output busy1, busy2);

endinterface

//--- hdl/free_list.sv
`timescale 1ns/1ps

module free_list (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic [core_cfg_pkg::N_LANES-1:0] i_need,
	input  logic i_take,
	input  logic [core_cfg_pkg::N_COM-1:0] i_com_en,
	input  logic [core_cfg_pkg::N_COM-1:0][core_cfg_pkg::WIDTH_PRD-1:0] i_com_prd,
	output logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] o_head,
	output logic o_grant
);

	logic [core_cfg_pkg::N_LANES-1:0] nonempty;

	// one circular FIFO per lane
	for (genvar b = 0; b < core_cfg_pkg::N_LANES; b++) begin : g_bank
		// bank 0 starts one tag late so tag 0 is never handed out
		localparam int FIRST = (b == 0) ? rename_enc_pkg::BANK0_FIRST : 0;
		localparam int INIT_CNT = core_cfg_pkg::BANK_DEPTH - FIRST;

		logic [core_cfg_pkg::WIDTH_PRD-1:0]  mem [core_cfg_pkg::BANK_DEPTH];
		logic [core_cfg_pkg::WIDTH_SLOT-1:0] head;
		logic [core_cfg_pkg::WIDTH_SLOT-1:0] tail;
		logic [core_cfg_pkg::WIDTH_CNT-1:0]  count;
		logic                                pop;
		logic [core_cfg_pkg::N_COM-1:0]      push;
		logic [core_cfg_pkg::N_COM-1:0][core_cfg_pkg::WIDTH_SLOT-1:0] wr_idx;
		logic [2:0]                          n_push;

		assign pop = i_take && i_need[b];
		assign nonempty[b] = (count != '0);
		assign o_head[b] = mem[head];

		// commit ports that return a tag to this bank, packed behind the tail
		always_comb begin
			n_push = '0;
			for (int c = 0; c < core_cfg_pkg::N_COM; c++) begin
				push[c] = i_com_en[c]
				          && (i_com_prd[c][core_cfg_pkg::WIDTH_PRD-1 -: core_cfg_pkg::WIDTH_BANK]
				              == core_cfg_pkg::WIDTH_BANK'(b))
				          && (i_com_prd[c] != rename_enc_pkg::PRD_ZERO);
				wr_idx[c] = tail + core_cfg_pkg::WIDTH_SLOT'(n_push);
				n_push = n_push + 3'(push[c]);
			end
		end

		always_ff @(posedge i_clk) begin
			if (!i_rst_n) begin
				// full bank, ascending order
				for (int s = 0; s < core_cfg_pkg::BANK_DEPTH; s++) begin
					mem[s] <= core_cfg_pkg::WIDTH_PRD'(b * rename_enc_pkg::BANK_STRIDE + FIRST + s);
				end
				head  <= '0;
				tail  <= core_cfg_pkg::WIDTH_SLOT'(INIT_CNT);
				count <= core_cfg_pkg::WIDTH_CNT'(INIT_CNT);
			end else begin
				for (int c = 0; c < core_cfg_pkg::N_COM; c++) begin
					if (push[c]) begin
						mem[wr_idx[c]] <= i_com_prd[c];
					end
				end
				if (pop) begin
					head <= head + 1'b1;
				end
				tail  <= tail + core_cfg_pkg::WIDTH_SLOT'(n_push);
				count <= count + core_cfg_pkg::WIDTH_CNT'(n_push)
				         - core_cfg_pkg::WIDTH_CNT'(pop);
			end
		end
	end

	// every lane that wants a tag must find one
	assign o_grant = &(~i_need | nonempty);

endmodule

//--- hdl/rename_map.sv
`timescale 1ns/1ps

module rename_map (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_valid,
	input  logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_ARCH-1:0] i_rs1,
	input  logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_ARCH-1:0] i_rs2,
	input  logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_ARCH-1:0] i_rd,
	input  logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0]  i_head,
	input  logic i_grant,
	output logic [core_cfg_pkg::N_LANES-1:0] o_need,
	output logic o_take,
	busy_if.map_side bif,
	output logic o_valid,
	output logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] o_prs1,
	output logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] o_prs2,
	output logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] o_prd,
	output logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] o_old_prd,
	output logic [core_cfg_pkg::N_LANES-1:0] o_rdy1,
	output logic [core_cfg_pkg::N_LANES-1:0] o_rdy2
);

	logic [core_cfg_pkg::WIDTH_PRD-1:0] map [core_cfg_pkg::N_ARCH];

	logic                                                           take;
	logic [core_cfg_pkg::N_LANES-1:0]                               has_rd;
	logic [core_cfg_pkg::N_LANES-1:0]                               need;
	logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0]  new_prd;
	logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0]  prs1;
	logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0]  prs2;
	logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0]  old_prd;
	logic [core_cfg_pkg::N_LANES-1:0]                               dep1;
	logic [core_cfg_pkg::N_LANES-1:0]                               dep2;

	// new tag per lane, zero tag when there is no destination
	always_comb begin
		for (int l = 0; l < core_cfg_pkg::N_LANES; l++) begin
			has_rd[l] = (i_rd[l] != rename_enc_pkg::ARCH_ZERO);
			need[l] = i_valid && has_rd[l];
			new_prd[l] = has_rd[l] ? i_head[l] : rename_enc_pkg::PRD_ZERO;
		end
	end

	assign take = i_valid && i_grant;
	assign o_need = need;
	assign o_take = take;

	// table read, then override from earlier lanes of the same group
	// later k wins, so the nearest earlier writer is taken
	always_comb begin
		for (int l = 0; l < core_cfg_pkg::N_LANES; l++) begin
			prs1[l] = map[i_rs1[l]];
			prs2[l] = map[i_rs2[l]];
			old_prd[l] = map[i_rd[l]];
			dep1[l] = 1'b0;
			dep2[l] = 1'b0;
			for (int k = 0; k < l; k++) begin
				if (has_rd[k] && (i_rd[k] == i_rs1[l])) begin
					prs1[l] = new_prd[k];
					dep1[l] = 1'b1;
				end
				if (has_rd[k] && (i_rd[k] == i_rs2[l])) begin
					prs2[l] = new_prd[k];
					dep2[l] = 1'b1;
				end
				if (has_rd[k] && (i_rd[k] == i_rd[l])) begin
					old_prd[l] = new_prd[k];
				end
			end
		end
	end

	// busy table side
	assign bif.set_mask = {core_cfg_pkg::N_LANES{take}} & need;
	assign bif.set_prd = new_prd;
	assign bif.look_rs1 = prs1;
	assign bif.look_rs2 = prs2;

	// map update in lane order
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int a = 0; a < core_cfg_pkg::N_ARCH; a++) begin
				map[a] <= rename_enc_pkg::PRD_ZERO;
			end
		end else if (take) begin
			for (int l = 0; l < core_cfg_pkg::N_LANES; l++) begin
				if (has_rd[l]) begin
					map[i_rd[l]] <= new_prd[l];
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= take;
		end
	end

	// output stage, valid for one cycle behind o_valid
	always_ff @(posedge i_clk) begin
		if (take) begin
			o_prs1    <= prs1;
			o_prs2    <= prs2;
			o_prd     <= new_prd;
			o_old_prd <= old_prd;
			o_rdy1    <= ~dep1 & ~bif.busy1;
			o_rdy2    <= ~dep2 & ~bif.busy2;
		end
	end

endmodule

//--- hdl/busy_table.sv
`timescale 1ns/1ps

module busy_table (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic [core_cfg_pkg::N_WB-1:0] i_wb_en,
	input  logic [core_cfg_pkg::N_WB-1:0][core_cfg_pkg::WIDTH_PRD-1:0] i_wb_prd,
	busy_if.table_side bif
);

	logic [core_cfg_pkg::N_PRD-1:0] busy;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			busy <= '0;
		end else begin
			// writeback clears first
			for (int w = 0; w < core_cfg_pkg::N_WB; w++) begin
				if (i_wb_en[w]) begin
					busy[i_wb_prd[w]] <= 1'b0;
				end
			end
			// rename set comes last and overrides a clear of the same tag
			for (int l = 0; l < core_cfg_pkg::N_LANES; l++) begin
				if (bif.set_mask[l]) begin
					busy[bif.set_prd[l]] <= 1'b1;
				end
			end
		end
	end

	// lookup sees the state before the edge, no writeback forwarding
	always_comb begin
		for (int l = 0; l < core_cfg_pkg::N_LANES; l++) begin
			bif.busy1[l] = busy[bif.look_rs1[l]]
			               && (bif.look_rs1[l] != rename_enc_pkg::PRD_ZERO);
			bif.busy2[l] = busy[bif.look_rs2[l]]
			               && (bif.look_rs2[l] != rename_enc_pkg::PRD_ZERO);
		end
	end

endmodule

//--- hdl/rename_top.sv
`timescale 1ns/1ps

module rename_top (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_valid,
	input  logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_ARCH-1:0] i_rs1,
	input  logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_ARCH-1:0] i_rs2,
	input  logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_ARCH-1:0] i_rd,
	input  logic [core_cfg_pkg::N_WB-1:0] i_wb_en,
	input  logic [core_cfg_pkg::N_WB-1:0][core_cfg_pkg::WIDTH_PRD-1:0] i_wb_prd,
	input  logic [core_cfg_pkg::N_COM-1:0] i_com_en,
	input  logic [core_cfg_pkg::N_COM-1:0][core_cfg_pkg::WIDTH_PRD-1:0] i_com_prd,
	output logic o_stall,
	output logic o_valid,
	output logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] o_prs1,
	output logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] o_prs2,
	output logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] o_prd,
	output logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] o_old_prd,
	output logic [core_cfg_pkg::N_LANES-1:0] o_rdy1,
	output logic [core_cfg_pkg::N_LANES-1:0] o_rdy2
);

	logic [core_cfg_pkg::N_LANES-1:0]                              need;
	logic                                                          take;
	logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0] head;
	logic                                                          grant;

	busy_if m_busy_if ();

	free_list m_free_list (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_need    (need),
		.i_take    (take),
		.i_com_en  (i_com_en),
		.i_com_prd (i_com_prd),
		.o_head    (head),
		.o_grant   (grant)
	);

	rename_map m_rename_map (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_valid   (i_valid),
		.i_rs1     (i_rs1),
		.i_rs2     (i_rs2),
		.i_rd      (i_rd),
		.i_head    (head),
		.i_grant   (grant),
		.o_need    (need),
		.o_take    (take),
		.bif       (m_busy_if.map_side),
		.o_valid   (o_valid),
		.o_prs1    (o_prs1),
		.o_prs2    (o_prs2),
		.o_prd     (o_prd),
		.o_old_prd (o_old_prd),
		.o_rdy1    (o_rdy1),
		.o_rdy2    (o_rdy2)
	);

	busy_table m_busy_table (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_wb_en  (i_wb_en),
		.i_wb_prd (i_wb_prd),
		.bif      (m_busy_if.table_side)
	);

	// producer holds the group while a needed bank is empty
	assign o_stall = i_valid && !grant;

endmodule

//--- bench/rename_tb_table.svh
`ifndef RENAME_TB_TABLE_SVH
`define RENAME_TB_TABLE_SVH

// columns: reps, valid, rs1, rs2, rd, wb tag, commit tag, stall, next valid, care,
// then next-cycle prs1, prs2, prd, old_prd, rdy1, rdy2 (lane fields list lane 3 first)
localparam int N_ROWS = 11;

localparam row_t ROWS [N_ROWS] = '{
	// first group after reset, all sources on the zero tag
	'{8'd1, 1'b1, {5'd8, 5'd7, 5'd6, 5'd5}, {5'd12, 5'd11, 5'd10, 5'd9},
	  {5'd4, 5'd3, 5'd2, 5'd1}, 7'd0, 7'd0, 1'b0, 1'b1, 3'b111,
	  {4{7'd0}}, {4{7'd0}}, {7'd96, 7'd64, 7'd32, 7'd1}, {4{7'd0}}, 4'hf, 4'hf},
	// lane 1 without rd takes no tag, sources from the first group are busy
	'{8'd1, 1'b1, {5'd3, 5'd0, 5'd2, 5'd1}, {5'd0, 5'd0, 5'd0, 5'd4},
	  {5'd7, 5'd6, 5'd0, 5'd5}, 7'd0, 7'd0, 1'b0, 1'b1, 3'b111,
	  {7'd64, 7'd0, 7'd32, 7'd1}, {7'd0, 7'd0, 7'd0, 7'd96},
	  {7'd97, 7'd65, 7'd0, 7'd2}, {4{7'd0}}, 4'b0100, 4'b1110},
	// intra-group deps, x8 written by lanes 0 and 2
	'{8'd1, 1'b1, {5'd8, 5'd9, 5'd8, 5'd0}, {5'd5, 5'd8, 5'd0, 5'd1},
	  {5'd10, 5'd8, 5'd9, 5'd8}, 7'd0, 7'd0, 1'b0, 1'b1, 3'b111,
	  {7'd66, 7'd33, 7'd3, 7'd0}, {7'd2, 7'd3, 7'd0, 7'd1},
	  {7'd98, 7'd66, 7'd33, 7'd3}, {7'd0, 7'd3, 7'd0, 7'd0}, 4'b0001, 4'b0010},
	// last writer of x8 seen, same-edge writeback of 66 not forwarded
	'{8'd1, 1'b1, {5'd1, 5'd10, 5'd9, 5'd8}, {4{5'd0}},
	  {4{5'd0}}, 7'd66, 7'd0, 1'b0, 1'b1, 3'b111,
	  {7'd1, 7'd98, 7'd33, 7'd66}, {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, 4'b0000, 4'hf},
	// 66 now ready, 65 still busy
	'{8'd1, 1'b1, {5'd0, 5'd0, 5'd6, 5'd8}, {4{5'd0}},
	  {4{5'd0}}, 7'd0, 7'd0, 1'b0, 1'b1, 3'b111,
	  {7'd0, 7'd0, 7'd65, 7'd66}, {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, 4'b1101, 4'hf},
	// idle cycle
	'{8'd1, 1'b0, {4{5'd0}}, {4{5'd0}}, {4{5'd0}}, 7'd0, 7'd0, 1'b0, 1'b0, 3'b000,
	  {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, 4'h0, 4'h0},
	// drain bank 0 through tag 30
	'{8'd27, 1'b1, {4{5'd0}}, {4{5'd0}}, {5'd0, 5'd0, 5'd0, 5'd1}, 7'd0, 7'd0,
	  1'b0, 1'b1, 3'b000, {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, 4'h0, 4'h0},
	// last bank 0 tag
	'{8'd1, 1'b1, {5'd0, 5'd0, 5'd0, 5'd1}, {4{5'd0}}, {5'd0, 5'd0, 5'd0, 5'd1},
	  7'd0, 7'd0, 1'b0, 1'b1, 3'b111, {7'd0, 7'd0, 7'd0, 7'd30}, {4{7'd0}},
	  {7'd0, 7'd0, 7'd0, 7'd31}, {7'd0, 7'd0, 7'd0, 7'd30}, 4'b1110, 4'hf},
	// bank 0 empty, group held
	'{8'd2, 1'b1, {5'd0, 5'd0, 5'd0, 5'd1}, {4{5'd0}}, {5'd0, 5'd0, 5'd0, 5'd1},
	  7'd0, 7'd0, 1'b1, 1'b0, 3'b000, {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, 4'h0, 4'h0},
	// commit of tag 5 lands, still stalled this cycle
	'{8'd1, 1'b1, {5'd0, 5'd0, 5'd0, 5'd1}, {4{5'd0}}, {5'd0, 5'd0, 5'd0, 5'd1},
	  7'd0, 7'd5, 1'b1, 1'b0, 3'b000, {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, {4{7'd0}}, 4'h0, 4'h0},
	// held group gets the committed tag
	'{8'd1, 1'b1, {5'd0, 5'd0, 5'd0, 5'd1}, {4{5'd0}}, {5'd0, 5'd0, 5'd0, 5'd1},
	  7'd0, 7'd0, 1'b0, 1'b1, 3'b111, {7'd0, 7'd0, 7'd0, 7'd31}, {4{7'd0}},
	  {7'd0, 7'd0, 7'd0, 7'd5}, {7'd0, 7'd0, 7'd0, 7'd31}, 4'b1110, 4'hf}
};

`endif

//--- bench/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

	localparam int RST_CYCLES = 8;
	localparam logic [2:0] CARE_SRC = 3'b001;
	localparam logic [2:0] CARE_DST = 3'b010;
	localparam logic [2:0] CARE_RDY = 3'b100;

	typedef logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_ARCH-1:0] arch_vec_t;
	typedef logic [core_cfg_pkg::N_LANES-1:0][core_cfg_pkg::WIDTH_PRD-1:0]  tag_vec_t;
	typedef logic [core_cfg_pkg::N_LANES-1:0]                               lane_bits_t;

	// one table row, outputs other than stall belong to the following cycle
	typedef struct packed {
		logic [7:0]                         reps;
		logic                               valid;
		arch_vec_t                          rs1;
		arch_vec_t                          rs2;
		arch_vec_t                          rd;
		logic [core_cfg_pkg::WIDTH_PRD-1:0] wb;
		logic [core_cfg_pkg::WIDTH_PRD-1:0] com;
		logic                               stall;
		logic                               ovalid;
		logic [2:0]                         care;
		tag_vec_t                           prs1;
		tag_vec_t                           prs2;
		tag_vec_t                           prd;
		tag_vec_t                           old_prd;
		lane_bits_t                         rdy1;
		lane_bits_t                         rdy2;
	} row_t;

	localparam row_t IDLE = '0;

	`include "rename_tb_table.svh"

	logic                                                          i_clk;
	logic                                                          i_rst_n;
	logic                                                          i_valid;
	arch_vec_t                                                     i_rs1;
	arch_vec_t                                                     i_rs2;
	arch_vec_t                                                     i_rd;
	logic [core_cfg_pkg::N_WB-1:0]                                 i_wb_en;
	logic [core_cfg_pkg::N_WB-1:0][core_cfg_pkg::WIDTH_PRD-1:0]    i_wb_prd;
	logic [core_cfg_pkg::N_COM-1:0]                                i_com_en;
	logic [core_cfg_pkg::N_COM-1:0][core_cfg_pkg::WIDTH_PRD-1:0]   i_com_prd;
	logic                                                          o_stall;
	logic                                                          o_valid;
	tag_vec_t                                                      o_prs1;
	tag_vec_t                                                      o_prs2;
	tag_vec_t                                                      o_prd;
	tag_vec_t                                                      o_old_prd;
	lane_bits_t                                                    o_rdy1;
	lane_bits_t                                                    o_rdy2;

	int   errors = 0;
	int   checks = 0;
	int   cycle = 0;
	int   limit;
	row_t pending;

	rename_top DUT (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_valid   (i_valid),
		.i_rs1     (i_rs1),
		.i_rs2     (i_rs2),
		.i_rd      (i_rd),
		.i_wb_en   (i_wb_en),
		.i_wb_prd  (i_wb_prd),
		.i_com_en  (i_com_en),
		.i_com_prd (i_com_prd),
		.o_stall   (o_stall),
		.o_valid   (o_valid),
		.o_prs1    (o_prs1),
		.o_prs2    (o_prs2),
		.o_prd     (o_prd),
		.o_old_prd (o_old_prd),
		.o_rdy1    (o_rdy1),
		.o_rdy2    (o_rdy2)
	);

	always #5 i_clk = ~i_clk;

	// cycles taken by the table plus the closing idle cycle
	function automatic int table_cycles();
		int n;
		n = 1;
		for (int r = 0; r < N_ROWS; r++) begin
			n = n + int'(ROWS[r].reps);
		end
		return n;
	endfunction

	always @(posedge i_clk) begin
		cycle <= cycle + 1;
		if (cycle >= limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// writeback rides on port 2, commit on port 3
	task automatic apply_inputs(input row_t row);
		i_valid   <= row.valid;
		i_rs1     <= row.rs1;
		i_rs2     <= row.rs2;
		i_rd      <= row.rd;
		i_wb_en   <= (row.wb != '0) ? 3'b100 : 3'b000;
		i_wb_prd  <= {row.wb, 7'd0, 7'd0};
		i_com_en  <= (row.com != '0) ? 4'b1000 : 4'b0000;
		i_com_prd <= {row.com, {3{7'd0}}};
	endtask

	task automatic compare_field(input string name, input logic [31:0] act,
	                             input logic [31:0] exp);
		checks++;
		assert (act === exp) else begin
			$display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// stall of this cycle, registered outputs of the group before
	task automatic check_cycle(input row_t now, input row_t prev);
		compare_field("o_stall", 32'(o_stall), 32'(now.stall));
		compare_field("o_valid", 32'(o_valid), 32'(prev.ovalid));
		if ((prev.care & CARE_SRC) != '0) begin
			compare_field("o_prs1", 32'(o_prs1), 32'(prev.prs1));
			compare_field("o_prs2", 32'(o_prs2), 32'(prev.prs2));
		end
		if ((prev.care & CARE_DST) != '0) begin
			compare_field("o_prd", 32'(o_prd), 32'(prev.prd));
			compare_field("o_old_prd", 32'(o_old_prd), 32'(prev.old_prd));
		end
		if ((prev.care & CARE_RDY) != '0) begin
			compare_field("o_rdy1", 32'(o_rdy1), 32'(prev.rdy1));
			compare_field("o_rdy2", 32'(o_rdy2), 32'(prev.rdy2));
		end
	endtask

	initial begin
		i_clk     = 1'b0;
		i_rst_n   = 1'b0;
		i_valid   = 1'b0;
		i_rs1     = '0;
		i_rs2     = '0;
		i_rd      = '0;
		i_wb_en   = '0;
		i_wb_prd  = '0;
		i_com_en  = '0;
		i_com_prd = '0;
		limit     = 2 * (table_cycles() + RST_CYCLES);
		pending   = IDLE;

		repeat (RST_CYCLES) @(posedge i_clk);
		i_rst_n <= 1'b1;

		for (int r = 0; r < N_ROWS; r++) begin
			for (int n = 0; n < int'(ROWS[r].reps); n++) begin
				@(posedge i_clk);
				apply_inputs(ROWS[r]);
				@(negedge i_clk);
				check_cycle(ROWS[r], pending);
				pending = ROWS[r];
			end
		end

		// flush the last accepted group
		@(posedge i_clk);
		apply_inputs(IDLE);
		@(negedge i_clk);
		check_cycle(IDLE, pending);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+bench
hdl/core_cfg_pkg.sv
hdl/rename_enc_pkg.sv
hdl/busy_if.sv
hdl/free_list.sv
hdl/rename_map.sv
hdl/busy_table.sv
hdl/rename_top.sv
bench/rename_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rename testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module rename_tb -o rename_sim \
	&& ./obj_dir/rename_sim | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }

grep -q "TEST FAILED" sim.log && exit 1 || exit 0
